/* Makefile */
TOP := tb_uart_frame_analyser
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 --top-module $(TOP) -f sim.f --Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

lint:
	verilator --lint-only --timing --top-module uart_frame_analyser -f sim.f

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_uart_frame_analyser.sv */
// testbench for the UART frame analyser
// directed tests of bit order, parity, frame records and the frame queue

`timescale 1ns/1ps

`include "uart_frame_cfg.svh"

module tb_uart_frame_analyser;

    localparam int WRITE_TIMEOUT = 20;
    localparam int FRAME_TIMEOUT = 100;
    localparam int BYTE_TICKS    = 12;
    localparam int IDLE_TICKS    = 30;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      byte_sync_i;
    logic [`RX_WORD_W-1:0]     rx_word_i;
    logic                      baud_tick_i;
    logic                      parity_en_i;
    logic                      big_end_i;
    logic [`MS_STAMP_W-1:0]    ms_stamp_i;
    logic [`SUB_STAMP_W-1:0]   sub_stamp_i;
    logic                      byte_we_n_o;
    logic [`DATA_W-1:0]        byte_data_o;
    logic [`DATA_W-1:0]        parity_err_cnt_o;
    logic                      frame_rd_i;
    logic [`FRAME_Q_CNT_W-1:0] frame_count_o;
    logic [`MS_STAMP_W-1:0]    frame_ms_o;
    logic [`SUB_STAMP_W-1:0]   frame_sub_o;
    logic [`BYTE_CNT_W-1:0]    frame_bytes_o;

    int unsigned        seed_val;
    int                 checks;
    int                 errors;
    int                 timeouts;
    // expected parity error count
    logic [`DATA_W-1:0] exp_err_cnt;

    uart_frame_analyser i_dut (
        .clk              (clk),
        .rst              (rst),
        .byte_sync_i      (byte_sync_i),
        .rx_word_i        (rx_word_i),
        .baud_tick_i      (baud_tick_i),
        .parity_en_i      (parity_en_i),
        .big_end_i        (big_end_i),
        .ms_stamp_i       (ms_stamp_i),
        .sub_stamp_i      (sub_stamp_i),
        .byte_we_n_o      (byte_we_n_o),
        .byte_data_o      (byte_data_o),
        .parity_err_cnt_o (parity_err_cnt_o),
        .frame_rd_i       (frame_rd_i),
        .frame_count_o    (frame_count_o),
        .frame_ms_o       (frame_ms_o),
        .frame_sub_o      (frame_sub_o),
        .frame_bytes_o    (frame_bytes_o)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    // start 0, data 10..3, parity, stop 1, unused
    function automatic logic [11:0] make_word(input logic [7:0] field, input logic par);
        return {1'b0, field, par, 1'b1, 1'b0};
    endfunction

    function automatic logic [7:0] bit_reverse(input logic [7:0] v);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = v[7-i];
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_word(input logic [11:0] word, input logic [11:0] ms,
                              input logic [3:0] sub);
        rx_word_i   = word;
        ms_stamp_i  = ms;
        sub_stamp_i = sub;
        byte_sync_i = 1'b1;
        step_cycle();
        byte_sync_i = 1'b0;
    endtask

    // cycles counted from the edge that took the sync
    task automatic wait_write(output bit seen, output int cycles);
        cycles = 0;
        while (byte_we_n_o && cycles < WRITE_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        seen = !byte_we_n_o;
        if (!seen) begin
            report_timeout("byte write strobe");
        end
    endtask

    task automatic wait_parity_error(input logic [7:0] prev, output bit write_seen);
        int cycles;
        cycles = 0;
        write_seen = 1'b0;
        while (parity_err_cnt_o == prev && cycles < WRITE_TIMEOUT) begin
            step_cycle();
            cycles++;
            if (!byte_we_n_o) begin
                write_seen = 1'b1;
            end
        end
        if (parity_err_cnt_o == prev) begin
            report_timeout("parity error count");
        end
    endtask

    // one byte through the decoder with good or flipped parity
    task automatic send_byte(input logic [7:0] field, input bit good,
                             input logic [11:0] ms, input logic [3:0] sub);
        bit seen;
        bit write_seen;
        int cycles;
        logic [7:0] exp_data;
        exp_data = big_end_i ? field : bit_reverse(field);
        drive_word(make_word(field, good ? ^field : ~^field), ms, sub);
        if (good) begin
            wait_write(seen, cycles);
            if (seen) begin
                check_value("byte data", 32'(byte_data_o), 32'(exp_data));
            end
        end else begin
            wait_parity_error(exp_err_cnt, write_seen);
            exp_err_cnt = exp_err_cnt + 8'd1;
            check_value("write on bad parity", 32'(write_seen), 32'd0);
            check_value("parity error count", 32'(parity_err_cnt_o), 32'(exp_err_cnt));
        end
    endtask

    // one baud tick every 4 clocks
    task automatic send_ticks(input int n);
        for (int i = 0; i < n; i++) begin
            baud_tick_i = 1'b1;
            step_cycle();
            baud_tick_i = 1'b0;
            repeat (3) step_cycle();
        end
    endtask

    task automatic end_frame(input int exp_count);
        int cycles;
        send_ticks(IDLE_TICKS);
        cycles = 0;
        while (32'(frame_count_o) != exp_count && cycles < FRAME_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (32'(frame_count_o) != exp_count) begin
            report_timeout("frame count");
        end
    endtask

    // queue outputs change one edge after the edge that samples the strobe
    task automatic read_frame(input int count_before);
        frame_rd_i = 1'b1;
        step_cycle();
        frame_rd_i = 1'b0;
        check_value("frame count at read edge", 32'(frame_count_o), 32'(count_before));
        step_cycle();
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic after_reset();
        check_value("reset byte_we_n", 32'(byte_we_n_o), 32'd1);
        check_value("reset parity errors", 32'(parity_err_cnt_o), 32'd0);
        check_value("reset frame count", 32'(frame_count_o), 32'd0);
        check_value("reset frame ms", 32'(frame_ms_o), 32'd0);
        check_value("reset frame sub", 32'(frame_sub_o), 32'd0);
        check_value("reset frame bytes", 32'(frame_bytes_o), 32'd0);
    endtask

    task automatic bit_order();
        logic [7:0] field;
        logic [7:0] exp_data;
        bit seen;
        int cycles;
        parity_en_i = 1'b0;
        for (int i = 0; i < 8; i++) begin
            field     = 8'($urandom);
            big_end_i = i[0];
            exp_data  = big_end_i ? field : bit_reverse(field);
            // wrong parity bit is ignored while parity is off
            drive_word(make_word(field, ~^field), 12'h0, 4'h0);
            wait_write(seen, cycles);
            if (seen) begin
                check_value("write latency", 32'(cycles), 32'd5);
                check_value("byte data", 32'(byte_data_o), 32'(exp_data));
                step_cycle();
                check_value("write strobe width", 32'(byte_we_n_o), 32'd1);
            end
        end
        check_value("parity errors while off", 32'(parity_err_cnt_o), 32'(exp_err_cnt));
    endtask

    task automatic parity_handling();
        parity_en_i = 1'b1;
        big_end_i   = 1'b1;
        send_byte(8'($urandom), 1'b1, 12'h0, 4'h0);
        check_value("parity errors after good byte", 32'(parity_err_cnt_o),
                    32'(exp_err_cnt));
        send_byte(8'($urandom), 1'b0, 12'h0, 4'h0);
        send_byte(8'($urandom), 1'b1, 12'h0, 4'h0);
        check_value("parity errors after good byte", 32'(parity_err_cnt_o),
                    32'(exp_err_cnt));
    endtask

    task automatic frame_record();
        // bytes of the earlier tests form a frame of their own
        end_frame(1);
        read_frame(1);
        check_value("queue empty before frame test", 32'(frame_count_o), 32'd0);
        parity_en_i = 1'b1;
        big_end_i   = 1'b1;
        // five good bytes with the third one sent bad
        for (int i = 0; i < 6; i++) begin
            if (i > 0) begin
                send_ticks(BYTE_TICKS);
            end
            send_byte(8'($urandom), i != 2, 12'(12'h100 + i), 4'(i + 3));
        end
        end_frame(1);
        read_frame(1);
        check_value("frame bytes", 32'(frame_bytes_o), 32'd5);
        check_value("frame ms stamp", 32'(frame_ms_o), 32'h105);
        check_value("frame sub stamp", 32'(frame_sub_o), 32'd8);
        check_value("frame count after read", 32'(frame_count_o), 32'd0);
    endtask

    task automatic queue_overflow();
        // frame f holds f bytes
        for (int f = 1; f <= 5; f++) begin
            for (int b = 0; b < f; b++) begin
                if (b > 0) begin
                    send_ticks(BYTE_TICKS);
                end
                send_byte(8'($urandom), 1'b1, 12'(f * 16 + b), 4'(f));
            end
            end_frame(f < `FRAME_Q_DEPTH ? f : `FRAME_Q_DEPTH);
        end
        check_value("full queue count", 32'(frame_count_o), 32'd4);
        // frame 1 was dropped
        for (int f = 2; f <= 5; f++) begin
            read_frame(6 - f);
            check_value("queued frame bytes", 32'(frame_bytes_o), 32'(f));
            check_value("queued frame ms", 32'(frame_ms_o), 32'(f * 16 + f - 1));
            check_value("queued frame sub", 32'(frame_sub_o), 32'(f));
        end
        check_value("drained queue count", 32'(frame_count_o), 32'd0);
        read_frame(0);
        check_value("empty read count", 32'(frame_count_o), 32'd0);
        check_value("empty read bytes", 32'(frame_bytes_o), 32'd5);
        check_value("empty read ms", 32'(frame_ms_o), 32'(5 * 16 + 4));
        check_value("empty read sub", 32'(frame_sub_o), 32'd5);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        rst         = 1'b0;
        byte_sync_i = 1'b0;
        rx_word_i   = '0;
        baud_tick_i = 1'b0;
        parity_en_i = 1'b0;
        big_end_i   = 1'b1;
        ms_stamp_i  = '0;
        sub_stamp_i = '0;
        frame_rd_i  = 1'b0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        exp_err_cnt = '0;
        seed_val    = $urandom(32'h6e07_0a83);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        step_cycle();

        after_reset();
        bit_order();
        parity_handling();
        frame_record();
        queue_overflow();

        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* include/uart_frame_cfg.svh */
// UART frame analyser configuration
// widths, frame gap limit and frame queue depth

`ifndef UART_FRAME_CFG_SVH
`define UART_FRAME_CFG_SVH

// ----------------------------------------
// receive word and data byte
// ----------------------------------------
`define RX_WORD_W       12
`define DATA_W          8

// ----------------------------------------
// frame detection
// ----------------------------------------
// gap counter saturates at all ones
`define INTERVAL_CNT_W  8
// 11 ticks per byte plus 17 ticks of slack inside a frame
`define FRAME_GAP_BAUDS 28
`define BYTE_CNT_W      8

// time stamp inputs
`define MS_STAMP_W      12
`define SUB_STAMP_W     4

// ----------------------------------------
// frame record queue
// ----------------------------------------
`define FRAME_Q_DEPTH   4
`define FRAME_Q_CNT_W   3

`endif

/* sim.f */
+incdir+include
src/uart_frame_pkg.sv
src/frame_event_if.sv
src/byte_decoder.sv
src/frame_tracker.sv
src/frame_info_queue.sv
src/uart_frame_analyser.sv
dv/tb_uart_frame_analyser.sv

/* src/byte_decoder.sv */
// byte decoder
// runs each received word through buffer, bit order, parity check and
// write, and counts the bytes that fail parity

`timescale 1ns/1ps

`include "uart_frame_cfg.svh"

module byte_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 byte_sync_i,
    input  logic [`RX_WORD_W-1:0] rx_word_i,
    input  logic                 parity_en_i,
    input  logic                 big_end_i,
    frame_event_if.decoder       ev,
    output logic                 byte_we_n_o,
    output logic [`DATA_W-1:0]   byte_data_o,
    output logic [`DATA_W-1:0]   parity_err_cnt_o
);

    // word layout: data in 10..3, parity in 2
    localparam int DATA_LSB = 3;
    localparam int PAR_BIT  = 2;

    uart_frame_pkg::decode_state_e state_r;

    logic                sync_q_r;
    logic                accept;
    logic [`DATA_W-1:0]  raw_data_r;
    logic                raw_par_r;
    logic                parity_en_r;
    logic                big_end_r;
    logic [`DATA_W-1:0]  data_rev;
    logic [`DATA_W-1:0]  data_r;
    logic                parity_ok_r;
    logic                we_n_r;
    logic [`DATA_W-1:0]  err_cnt_r;

    // busy from the cycle after a word is taken
    assign ev.decoder_idle = (state_r == uart_frame_pkg::IDLE) && !sync_q_r;
    assign accept          = byte_sync_i && ev.decoder_idle;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_r  <= uart_frame_pkg::IDLE;
            sync_q_r <= 1'b0;
        end else begin
            sync_q_r <= accept;
            case (state_r)
                uart_frame_pkg::IDLE: begin
                    if (sync_q_r) begin
                        state_r <= uart_frame_pkg::BUFF;
                    end
                end
                uart_frame_pkg::BUFF: state_r <= uart_frame_pkg::PARR;
                uart_frame_pkg::PARR: state_r <= uart_frame_pkg::CHCK;
                uart_frame_pkg::CHCK: state_r <= uart_frame_pkg::FIFO;
                uart_frame_pkg::FIFO: state_r <= uart_frame_pkg::IDLE;
                default:              state_r <= uart_frame_pkg::IDLE;
            endcase
        end
    end

    // little end order, field reversed
    always_comb begin
        for (int i = 0; i < `DATA_W; i++) begin
            data_rev[i] = raw_data_r[`DATA_W-1-i];
        end
    end

    // ----------------------------------------
    // data path
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            raw_data_r <= rx_word_i[DATA_LSB +: `DATA_W];
            raw_par_r  <= rx_word_i[PAR_BIT];
        end
        // settings held for the whole byte
        if (state_r == uart_frame_pkg::BUFF) begin
            parity_en_r <= parity_en_i;
            big_end_r   <= big_end_i;
        end
        if (state_r == uart_frame_pkg::PARR) begin
            data_r <= big_end_r ? raw_data_r : data_rev;
        end
        // even parity over the data bits
        if (state_r == uart_frame_pkg::CHCK) begin
            parity_ok_r <= !parity_en_r || ((^raw_data_r) == raw_par_r);
        end
    end

    // ----------------------------------------
    // write strobe and error count
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            we_n_r    <= 1'b1;
            err_cnt_r <= '0;
        end else begin
            we_n_r <= 1'b1;
            if (state_r == uart_frame_pkg::FIFO) begin
                if (parity_ok_r) begin
                    we_n_r <= 1'b0;
                end else begin
                    // wraps
                    err_cnt_r <= err_cnt_r + 1'b1;
                end
            end
        end
    end

    assign ev.byte_good      = ~we_n_r;
    assign byte_we_n_o       = we_n_r;
    assign byte_data_o       = data_r;
    assign parity_err_cnt_o  = err_cnt_r;

endmodule

/* src/frame_event_if.sv */
// frame event interface
// byte and frame events between decoder, tracker and frame queue

`timescale 1ns/1ps

interface frame_event_if;

    // pulse per accepted byte
    logic byte_good;
    // decoder ready for a new word
    logic decoder_idle;
    // pulse per closed frame
    logic frame_push;
    // record, valid with frame_push
    uart_frame_pkg::frame_info_t frame_info;

    modport decoder (
        output byte_good,
        output decoder_idle
    );

    modport tracker (
        input  byte_good,
        input  decoder_idle,
        output frame_push,
        output frame_info
    );

    modport queue (
        input  frame_push,
        input  frame_info
    );

endinterface

/* src/frame_info_queue.sv */
// frame record queue
// oldest-first store of closed frames; overflow drops the oldest,
// reads load a registered output port

`timescale 1ns/1ps

`include "uart_frame_cfg.svh"

module frame_info_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     frame_rd_i,
    frame_event_if.queue             ev,
    output logic [`FRAME_Q_CNT_W-1:0] frame_count_o,
    output logic [`MS_STAMP_W-1:0]   frame_ms_o,
    output logic [`SUB_STAMP_W-1:0]  frame_sub_o,
    output logic [`BYTE_CNT_W-1:0]   frame_bytes_o
);

    localparam int DEPTH = `FRAME_Q_DEPTH;
    localparam int CNT_W = `FRAME_Q_CNT_W;
    localparam int IDX_W = $clog2(DEPTH);

    // entry 0 is the oldest
    uart_frame_pkg::frame_info_t q_r [DEPTH];
    uart_frame_pkg::frame_info_t out_r;

    logic [CNT_W-1:0] cnt_r;
    logic             rd_q_r;
    logic             full;
    logic             rd_ok;
    logic             shift;
    logic [CNT_W-1:0] wr_pos;

    assign full  = (cnt_r == CNT_W'(DEPTH));
    // read strobe takes effect one edge after it is sampled
    assign rd_ok = rd_q_r && (cnt_r != '0);
    // a read or an overflow both retire the head
    assign shift = rd_ok || (ev.frame_push && full);
    // first free slot once the shift is done
    assign wr_pos = cnt_r - CNT_W'(shift);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (shift) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                q_r[i] <= q_r[i+1];
            end
        end
        if (ev.frame_push) begin
            q_r[wr_pos[IDX_W-1:0]] <= ev.frame_info;
        end
    end

    // ----------------------------------------
    // occupancy and read port
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_q_r <= 1'b0;
            cnt_r  <= '0;
            out_r  <= '0;
        end else begin
            rd_q_r <= frame_rd_i;
            if (ev.frame_push && !rd_ok && !full) begin
                cnt_r <= cnt_r + 1'b1;
            end else if (rd_ok && !ev.frame_push) begin
                cnt_r <= cnt_r - 1'b1;
            end
            // held until the next valid read
            if (rd_ok) begin
                out_r <= q_r[0];
            end
        end
    end

    assign frame_count_o = cnt_r;
    assign frame_ms_o    = out_r.ms_stamp;
    assign frame_sub_o   = out_r.sub_stamp;
    assign frame_bytes_o = out_r.byte_cnt;

endmodule

/* src/frame_tracker.sv */
// frame tracker
// measures the idle gap between bytes in baud ticks, counts the good
// bytes of a frame and emits a stamped record when the frame ends

`timescale 1ns/1ps

`include "uart_frame_cfg.svh"

module frame_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    byte_sync_i,
    input  logic                    baud_tick_i,
    input  logic [`MS_STAMP_W-1:0]  ms_stamp_i,
    input  logic [`SUB_STAMP_W-1:0] sub_stamp_i,
    frame_event_if.tracker          ev
);

    localparam int GAP_W = `INTERVAL_CNT_W;
    localparam logic [GAP_W-1:0] GAP_LIMIT = GAP_W'(`FRAME_GAP_BAUDS);
    localparam int BCNT_W = `BYTE_CNT_W;

    logic [GAP_W-1:0]          gap_cnt_r;
    logic                      gap_flag_r;
    logic [BCNT_W-1:0]         byte_cnt_r;
    logic [`MS_STAMP_W-1:0]    ms_r;
    logic [`SUB_STAMP_W-1:0]   sub_r;
    logic                      close;
    logic                      push_r;
    uart_frame_pkg::frame_info_t info_r;

    // ----------------------------------------
    // gap measurement
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // saturated, no frame open
            gap_cnt_r  <= '1;
            gap_flag_r <= 1'b1;
        end else if (byte_sync_i) begin
            gap_cnt_r  <= '0;
            gap_flag_r <= 1'b0;
        end else if (baud_tick_i) begin
            if (gap_cnt_r != '1) begin
                gap_cnt_r <= gap_cnt_r + 1'b1;
            end
            if (gap_cnt_r >= GAP_LIMIT) begin
                gap_flag_r <= 1'b1;
            end
        end
    end

    // start of the last byte
    always_ff @(posedge clk) begin
        if (byte_sync_i) begin
            ms_r  <= ms_stamp_i;
            sub_r <= sub_stamp_i;
        end
    end

    // ----------------------------------------
    // frame close
    // ----------------------------------------
    // wait for the decoder so a byte in flight lands in this frame
    assign close = ev.decoder_idle && gap_flag_r && (byte_cnt_r != '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            byte_cnt_r <= '0;
            push_r     <= 1'b0;
        end else begin
            push_r <= close;
            if (close) begin
                byte_cnt_r <= BCNT_W'(ev.byte_good);
            end else if (ev.byte_good) begin
                byte_cnt_r <= byte_cnt_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (close) begin
            info_r.sub_stamp <= sub_r;
            info_r.ms_stamp  <= ms_r;
            info_r.byte_cnt  <= byte_cnt_r;
        end
    end

    assign ev.frame_push = push_r;
    assign ev.frame_info = info_r;

endmodule

/* src/uart_frame_analyser.sv */
// UART frame analyser
// receive-side byte decoder with parity error count, frame detection
// by idle gap and a queue of stamped frame records for the host

`timescale 1ns/1ps

`include "uart_frame_cfg.svh"

module uart_frame_analyser (
    input  logic                     clk,
    input  logic                     rst,
    // shift register side
    input  logic                     byte_sync_i,
    input  logic [`RX_WORD_W-1:0]    rx_word_i,
    input  logic                     baud_tick_i,
    // control
    input  logic                     parity_en_i,
    input  logic                     big_end_i,
    // time stamps
    input  logic [`MS_STAMP_W-1:0]   ms_stamp_i,
    input  logic [`SUB_STAMP_W-1:0]  sub_stamp_i,
    // byte write port
    output logic                     byte_we_n_o,
    output logic [`DATA_W-1:0]       byte_data_o,
    output logic [`DATA_W-1:0]       parity_err_cnt_o,
    // frame record read port
    input  logic                     frame_rd_i,
    output logic [`FRAME_Q_CNT_W-1:0] frame_count_o,
    output logic [`MS_STAMP_W-1:0]   frame_ms_o,
    output logic [`SUB_STAMP_W-1:0]  frame_sub_o,
    output logic [`BYTE_CNT_W-1:0]   frame_bytes_o
);

    frame_event_if ev_if ();

    byte_decoder i_decoder (
        .clk              (clk),
        .rst              (rst),
        .byte_sync_i      (byte_sync_i),
        .rx_word_i        (rx_word_i),
        .parity_en_i      (parity_en_i),
        .big_end_i        (big_end_i),
        .ev               (ev_if.decoder),
        .byte_we_n_o      (byte_we_n_o),
        .byte_data_o      (byte_data_o),
        .parity_err_cnt_o (parity_err_cnt_o)
    );

    frame_tracker i_tracker (
        .clk         (clk),
        .rst         (rst),
        .byte_sync_i (byte_sync_i),
        .baud_tick_i (baud_tick_i),
        .ms_stamp_i  (ms_stamp_i),
        .sub_stamp_i (sub_stamp_i),
        .ev          (ev_if.tracker)
    );

    frame_info_queue i_queue (
        .clk           (clk),
        .rst           (rst),
        .frame_rd_i    (frame_rd_i),
        .ev            (ev_if.queue),
        .frame_count_o (frame_count_o),
        .frame_ms_o    (frame_ms_o),
        .frame_sub_o   (frame_sub_o),
        .frame_bytes_o (frame_bytes_o)
    );

endmodule

/* src/uart_frame_pkg.sv */
// UART frame analyser types
// decoder state encoding and the frame record layout

`include "uart_frame_cfg.svh"

package uart_frame_pkg;

    // ----------------------------------------
    // byte decoder FSM, one-hot
    // ----------------------------------------
    typedef enum logic [4:0] {
        // waiting for a received word
        IDLE = 5'b0_0001,
        // snapshot of the per-byte settings
        BUFF = 5'b0_0010,
        // bit order applied to the data
        PARR = 5'b0_0100,
        // parity compare
        CHCK = 5'b0_1000,
        // byte written or counted as error
        FIFO = 5'b1_0000
    } decode_state_e;

    // ----------------------------------------
    // frame record
    // ----------------------------------------
    // stamps belong to the start of the last byte of the frame
    typedef struct packed {
        logic [`SUB_STAMP_W-1:0] sub_stamp;
        logic [`MS_STAMP_W-1:0]  ms_stamp;
        logic [`BYTE_CNT_W-1:0]  byte_cnt;
    } frame_info_t;

endpackage
